// ==== Bender.yml ====
package:
  name: ddr_sched

sources:
  - include_dirs:
      - hw
    files:
      - hw/ddr_sched_pkg.sv
      - hw/ddr_cmd_sequencer.sv
      - hw/ddr_hold_timer.sv
      - hw/ddr_page_tracker.sv
      - hw/ddr_cmd_encoder.sv
      - hw/ddr_sched_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/ddr_sched_checks.sv
      - bench/ddr_sched_tb.sv

// ==== all.f ====
+incdir+hw
hw/ddr_sched_pkg.sv
hw/ddr_cmd_sequencer.sv
hw/ddr_hold_timer.sv
hw/ddr_page_tracker.sv
hw/ddr_cmd_encoder.sv
hw/ddr_sched_top.sv
bench/ddr_sched_checks.sv
bench/ddr_sched_tb.sv

// ==== bench/ddr_sched_checks.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_sched_checks
(
  input  logic                     INPUT_CLK,
  input  logic                     RST,
  input  logic                     refresh_strobe,
  input  ddr_sched_pkg::req_addr_u rand_addr,
  input  logic                     rand_we,
  input  logic                     rand_req,
  input  logic                     rand_grant,
  input  ddr_sched_pkg::req_addr_u bulk_addr,
  input  logic                     bulk_we,
  input  logic                     bulk_req,
  input  logic                     bulk_grant,
  input  logic [`CMD_W-1:0]        ddr_cmd,
  input  logic [`DDR_ADDR_W-1:0]   ddr_addr,
  input  logic [`BANK_W-1:0]       ddr_bank,
  output logic                     check_error
);
  import ddr_sched_pkg::*;

  localparam int REFRESH_LIMIT = 200;
  localparam int WAIT_LIMIT    = 4000; // Cycles a request may wait

  logic               row_open;        // Reference bank state
  logic [`ROW_W-1:0]  open_row;
  logic [`BANK_W-1:0] open_bank;
  logic [`CMD_W-1:0]  last_cmd;
  logic               strobe_q;
  logic               refresh_pending;
  logic               is_rw;
  int                 gap;             // Cycles since last command
  int                 refresh_age;
  int                 rand_age;
  int                 bulk_age;

  initial check_error = 1'b0;

  function automatic int spacing_after(input logic [`CMD_W-1:0] cmd);
    case (cmd)
      `CMD_ACTV:                       return 4;
      `CMD_READ, `CMD_WRTE, `CMD_PRCH: return 5;
      `CMD_ARSR:                       return 14;
      default:                         return 0;
    endcase
  endfunction

  // Column moved up one bit on the address pins
  function automatic logic [`DDR_ADDR_W-1:0] rw_column(input req_addr_u a);
    logic [`DDR_ADDR_W-1:0] col;
    col = a.rbc.col;
    return col << 1;
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    check_error = 1'b1;
  endtask

  task automatic raise_error(input string what);
    $display("Error at %0t: %s", $time, what);
    check_error = 1'b1;
  endtask

  assign is_rw = (ddr_cmd == `CMD_READ) || (ddr_cmd == `CMD_WRTE);

  // ------------------------------------------------------------
  // Reference model, updated from the command bus
  // ------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    strobe_q <= refresh_strobe;
    if (RST)
    begin
      row_open        <= 1'b0;
      last_cmd        <= `CMD_NOOP;
      gap             <= 1000;
      refresh_pending <= 1'b0;
      refresh_age     <= 0;
      rand_age        <= 0;
      bulk_age        <= 0;
    end
    else
    begin
      if (ddr_cmd == `CMD_ACTV)
      begin
        row_open  <= 1'b1;
        open_row  <= ddr_addr;
        open_bank <= ddr_bank;
      end
      if (ddr_cmd == `CMD_PRCH)
        row_open <= 1'b0;
      if (ddr_cmd != `CMD_NOOP)
      begin
        last_cmd <= ddr_cmd;
        gap      <= 1;
      end
      else if (gap < 1000)
        gap <= gap + 1;
      if (refresh_strobe != strobe_q)
      begin
        refresh_pending <= 1'b1; // New refresh request
        refresh_age     <= 0;
      end
      else if (ddr_cmd == `CMD_ARSR)
        refresh_pending <= 1'b0;
      else if (refresh_pending)
        refresh_age <= refresh_age + 1;
      rand_age <= (rand_req && !rand_grant) ? rand_age + 1 : 0;
      bulk_age <= (bulk_req && !bulk_grant) ? bulk_age + 1 : 0;
    end
  end

  a_reset_noop: assert property (@(posedge INPUT_CLK) RST |=> ddr_cmd == `CMD_NOOP)
    else show_mismatch("ddr_cmd", `CMD_NOOP, $sampled(ddr_cmd));
  a_reset_grant: assert property (@(posedge INPUT_CLK) RST |=> !rand_grant && !bulk_grant)
    else raise_error("a grant is high right after reset");
  a_noop_after: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd != `CMD_NOOP |=> ddr_cmd == `CMD_NOOP)
    else show_mismatch("ddr_cmd", `CMD_NOOP, $sampled(ddr_cmd));
  a_rw_granted: assert property (@(posedge INPUT_CLK) disable iff (RST)
    is_rw |-> rand_grant || bulk_grant)
    else raise_error("READ or WRITE issued without a grant");
  a_grant_rw: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant || bulk_grant |-> is_rw)
    else raise_error("grant high outside a READ or WRITE cycle");

  // ------------------------------------------------------------
  // Granted access matches the request
  // ------------------------------------------------------------
  a_rand_cmd: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant |-> ddr_cmd == (rand_we ? `CMD_WRTE : `CMD_READ))
    else show_mismatch("ddr_cmd", $sampled(rand_we) ? `CMD_WRTE : `CMD_READ, $sampled(ddr_cmd));
  a_bulk_cmd: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_grant |-> ddr_cmd == (bulk_we ? `CMD_WRTE : `CMD_READ))
    else show_mismatch("ddr_cmd", $sampled(bulk_we) ? `CMD_WRTE : `CMD_READ, $sampled(ddr_cmd));
  a_rand_bank: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant |-> ddr_bank == rand_addr.rbc.bank)
    else show_mismatch("ddr_bank", $sampled(rand_addr.rbc.bank), $sampled(ddr_bank));
  a_bulk_bank: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_grant |-> ddr_bank == bulk_addr.rbc.bank)
    else show_mismatch("ddr_bank", $sampled(bulk_addr.rbc.bank), $sampled(ddr_bank));
  a_rand_col: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant |-> ddr_addr == rw_column(rand_addr))
    else show_mismatch("ddr_addr", rw_column($sampled(rand_addr)), $sampled(ddr_addr));
  a_bulk_col: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_grant |-> ddr_addr == rw_column(bulk_addr))
    else show_mismatch("ddr_addr", rw_column($sampled(bulk_addr)), $sampled(ddr_addr));
  a_rand_row: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant |-> rand_addr.rbc.row == open_row)
    else show_mismatch("open row", $sampled(rand_addr.rbc.row), $sampled(open_row));
  a_bulk_row: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_grant |-> bulk_addr.rbc.row == open_row)
    else show_mismatch("open row", $sampled(bulk_addr.rbc.row), $sampled(open_row));

  // ------------------------------------------------------------
  // Row protocol, refresh and spacing
  // ------------------------------------------------------------
  a_actv_closed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd == `CMD_ACTV |-> !row_open)
    else raise_error("ACTIVATE issued while a row is already open");
  a_actv_row: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd == `CMD_ACTV |->
      (rand_req && ddr_addr == rand_addr.rbc.row && ddr_bank == rand_addr.rbc.bank) ||
      (bulk_req && ddr_addr == bulk_addr.rbc.row && ddr_bank == bulk_addr.rbc.bank))
    else raise_error($sformatf("ACTIVATE row %0h bank %0h matches no waiting request",
                               $sampled(ddr_addr), $sampled(ddr_bank)));
  a_prch_open: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd == `CMD_PRCH |-> row_open)
    else raise_error("PRECHARGE issued with no row open");
  a_prch_addr: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd == `CMD_PRCH |-> ddr_addr == `PRCH_ALL_ADDR)
    else show_mismatch("ddr_addr", `PRCH_ALL_ADDR, $sampled(ddr_addr));
  a_rw_open: assert property (@(posedge INPUT_CLK) disable iff (RST)
    is_rw |-> row_open)
    else raise_error("READ or WRITE issued with no row open");
  a_rw_bank: assert property (@(posedge INPUT_CLK) disable iff (RST)
    is_rw |-> ddr_bank == open_bank)
    else show_mismatch("ddr_bank", $sampled(open_bank), $sampled(ddr_bank));
  a_arsr_closed: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd == `CMD_ARSR |-> !row_open)
    else raise_error("AUTO REFRESH issued while a row is open");
  a_refresh_late: assert property (@(posedge INPUT_CLK) disable iff (RST)
    refresh_age <= REFRESH_LIMIT)
    else raise_error("refresh request not served within 200 cycles");
  a_spacing: assert property (@(posedge INPUT_CLK) disable iff (RST)
    ddr_cmd != `CMD_NOOP |-> gap >= spacing_after(last_cmd))
    else raise_error($sformatf("command %0b only %0d cycles after command %0b",
                               $sampled(ddr_cmd), $sampled(gap), $sampled(last_cmd)));
  a_rand_wait: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_age < WAIT_LIMIT)
    else raise_error("random port request never granted");
  a_bulk_wait: assert property (@(posedge INPUT_CLK) disable iff (RST)
    bulk_age < WAIT_LIMIT)
    else raise_error("bulk port request never granted");
  a_bulk_first: assert property (@(posedge INPUT_CLK) disable iff (RST)
    rand_grant && bulk_req && bulk_age >= 4 |-> bulk_addr.pg.page != rand_addr.pg.page)
    else raise_error("random port granted ahead of a bulk request on the same page");

endmodule

// ==== bench/ddr_sched_tb.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_sched_tb;
  import ddr_sched_pkg::*;

  localparam int ACCESS_COUNT     = 2000;
  localparam int CYCLES_PER_GRANT = 40; // Row changes and refresh included
  localparam int CYCLE_LIMIT      = ACCESS_COUNT * CYCLES_PER_GRANT;
  localparam int REFRESH_PERIOD   = 300;

  logic                   INPUT_CLK;
  logic                   RST;
  logic                   refresh_strobe;
  req_addr_u              rand_addr;
  logic                   rand_we;
  logic                   rand_req;
  logic                   rand_grant;
  req_addr_u              bulk_addr;
  logic                   bulk_we;
  logic                   bulk_req;
  logic                   bulk_grant;
  logic [`CMD_W-1:0]      ddr_cmd;
  logic [`DDR_ADDR_W-1:0] ddr_addr;
  logic [`BANK_W-1:0]     ddr_bank;
  logic                   check_error;
  int                     grant_count;
  int                     cycle_count;

  ddr_sched_top uut
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_addr      (rand_addr),
    .rand_we        (rand_we),
    .rand_req       (rand_req),
    .rand_grant     (rand_grant),
    .bulk_addr      (bulk_addr),
    .bulk_we        (bulk_we),
    .bulk_req       (bulk_req),
    .bulk_grant     (bulk_grant),
    .ddr_cmd        (ddr_cmd),
    .ddr_addr       (ddr_addr),
    .ddr_bank       (ddr_bank)
  );

  ddr_sched_checks u_checks
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_addr      (rand_addr),
    .rand_we        (rand_we),
    .rand_req       (rand_req),
    .rand_grant     (rand_grant),
    .bulk_addr      (bulk_addr),
    .bulk_we        (bulk_we),
    .bulk_req       (bulk_req),
    .bulk_grant     (bulk_grant),
    .ddr_cmd        (ddr_cmd),
    .ddr_addr       (ddr_addr),
    .ddr_bank       (ddr_bank),
    .check_error    (check_error)
  );

  always #10 INPUT_CLK = ~INPUT_CLK;

  // Four rows in two banks, so pages repeat often
  function automatic req_addr_u pick_address();
    req_addr_u a;
    a.rbc.row  = 14'h0101 * 14'($urandom_range(0, 3));
    a.rbc.bank = 3'($urandom_range(0, 1));
    a.rbc.col  = 9'($urandom);
    return a;
  endfunction

  // ------------------------------------------------------------
  // Requester, holds req until the grant edge has passed
  // ------------------------------------------------------------
  task automatic drive_requests(input bit bulk_port);
    int   idle;
    logic granted;
    forever
    begin
      idle = $urandom_range(0, 6);
      repeat (idle)
      begin
        @(posedge INPUT_CLK);
        #2;
      end
      if (bulk_port)
      begin
        bulk_addr = pick_address();
        bulk_we   = 1'($urandom_range(0, 1));
        bulk_req  = 1'b1;
      end
      else
      begin
        rand_addr = pick_address();
        rand_we   = 1'($urandom_range(0, 1));
        rand_req  = 1'b1;
      end
      granted = 1'b0;
      while (!granted)
      begin
        @(posedge INPUT_CLK);
        #2;
        granted = bulk_port ? bulk_grant : rand_grant; // Mid-cycle sample
      end
      @(posedge INPUT_CLK);
      #2;
      if (bulk_port)
        bulk_req = 1'b0;
      else
        rand_req = 1'b0;
      grant_count++;
    end
  endtask

  task automatic toggle_refresh();
    forever
    begin
      repeat (REFRESH_PERIOD) @(posedge INPUT_CLK);
      #2;
      refresh_strobe = ~refresh_strobe;
    end
  endtask

  initial
  begin
    wait (check_error === 1'b1);
    $display("Regression failed");
    $fatal(1, "stopped at the first failing check");
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge INPUT_CLK);
      cycle_count++;
    end
    $display("Timeout: %0d of %0d accesses granted after %0d cycles",
             grant_count, ACCESS_COUNT, cycle_count);
    $display("Regression failed");
    $fatal(1, "cycle limit reached");
  end

  initial
  begin
    void'($urandom(32'h142640b6));
    INPUT_CLK      = 1'b0;
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_addr      = '0;
    rand_we        = 1'b0;
    rand_req       = 1'b0;
    bulk_addr      = '0;
    bulk_we        = 1'b0;
    bulk_req       = 1'b0;
    grant_count    = 0;
    repeat (16) @(posedge INPUT_CLK);
    #2;
    RST = 1'b0;
    fork
      drive_requests(1'b0);
      drive_requests(1'b1);
      toggle_refresh();
    join_none
    wait (grant_count >= ACCESS_COUNT);
    @(posedge INPUT_CLK); // Last grant reaches the checks
    #2;
    if (check_error)
    begin
      $display("Regression failed");
      $fatal(1, "a check failed during the run");
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// ==== hw/ddr_cmd_encoder.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_cmd_encoder
(
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  logic                      issue,
  input  logic                      hit_rand,
  input  logic                      hit_bulk,
  input  logic                      page_active,
  input  logic                      refresh_time,
  input  logic                      actv_done,
  input  logic                      write_sel,
  input  ddr_sched_pkg::req_addr_u  rand_addr,
  input  ddr_sched_pkg::req_addr_u  bulk_addr,
  input  logic [`BANK_W-1:0]        cur_bank,
  input  logic [`PAGE_W-1:0]        cur_page,
  output logic [`CMD_W-1:0]         cmd_issued,
  output logic [`CMD_W-1:0]         ddr_cmd,
  output logic [`DDR_ADDR_W-1:0]    ddr_addr,
  output logic [`BANK_W-1:0]        ddr_bank,
  output logic                      rand_grant,
  output logic                      bulk_grant
);
  import ddr_sched_pkg::*;

  logic [`CMD_W-1:0]      cmd_non_rw;
  logic [`CMD_W-1:0]      cmd_next;
  logic [`DDR_ADDR_W-1:0] addr_next;
  logic [`BANK_W-1:0]     bank_next;
  logic [`CMD_W-1:0]      cmd_q;
  logic                   hit_any;
  req_addr_u              rw_addr;
  req_addr_u              actv_addr;

  assign hit_any = hit_rand || hit_bulk;
  assign rw_addr = hit_bulk ? bulk_addr : rand_addr;

  // Row key of the next ACTIVATE comes from the tracker
  assign actv_addr.pg = '{page: cur_page, col: '0};

  always_comb
  begin
    case ({page_active, refresh_time, actv_done})
      3'b101, 3'b111: cmd_non_rw = `CMD_PRCH;
      3'b010, 3'b011: cmd_non_rw = `CMD_ARSR;
      3'b000, 3'b001: cmd_non_rw = `CMD_ACTV;
      default:        cmd_non_rw = `CMD_NOOP; // Row too young to close
    endcase
  end

  assign cmd_next = hit_any ? (write_sel ? `CMD_WRTE : `CMD_READ) : cmd_non_rw;

  always_comb
  begin
    if (hit_any)
    begin
      addr_next = {{(`DDR_ADDR_W-`COL_W-1){1'b0}}, rw_addr.rbc.col, 1'b0};
      bank_next = cur_bank;
    end
    else if (page_active)
    begin
      addr_next = `PRCH_ALL_ADDR;
      bank_next = cur_bank;
    end
    else
    begin
      addr_next = actv_addr.rbc.row;
      bank_next = actv_addr.rbc.bank;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      cmd_q      <= `CMD_NOOP;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
    end
    else if (issue)
    begin
      cmd_q      <= cmd_next;
      bulk_grant <= hit_bulk;
      rand_grant <= hit_rand && !hit_bulk; // Bulk first on a shared page
    end
    else
    begin
      cmd_q      <= `CMD_NOOP;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      ddr_addr <= addr_next;
      ddr_bank <= bank_next;
    end
  end

  assign cmd_issued = cmd_q;
  assign ddr_cmd    = cmd_q;

  a_grant_onehot: assert property (@(posedge INPUT_CLK) disable iff (RST)
    $onehot0({rand_grant, bulk_grant}));

endmodule

// ==== hw/ddr_cmd_sequencer.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_cmd_sequencer
(
  input  logic              INPUT_CLK,
  input  logic              RST,
  input  logic              refresh_strobe,
  input  logic              rand_req,
  input  logic              hit_rand,
  input  logic              hit_bulk,
  input  logic              bulk_req_q,
  input  logic              rand_req_q,
  input  logic              write_sel,
  input  logic              last_write,
  input  logic              slot_open,
  input  logic [`CMD_W-1:0] cmd_issued,
  output logic              issue,
  output logic              settle,
  output logic              refresh_time
);

  logic second_stroke; // Low for the cycle after an issue
  logic refresh_ack;
  logic state_rw;      // Last issued command was READ or WRITE
  logic dir_match;
  logic issue_on_page;
  logic issue_override;

  assign settle = ~second_stroke;

  // Stay in the current transfer direction
  assign dir_match = last_write ? write_sel : ~write_sel;

  assign issue_on_page = second_stroke && state_rw && dir_match && slot_open &&
                         ((hit_rand && rand_req) || (hit_bulk && bulk_req_q));

  // Bulk shadows the random port
  assign issue_override = second_stroke && slot_open &&
                          ((rand_req_q && !bulk_req_q) || bulk_req_q || refresh_time);

  assign issue = issue_on_page || issue_override;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      second_stroke <= 1'b1;
      refresh_ack   <= 1'b0;
      refresh_time  <= 1'b0;
      state_rw      <= 1'b0;
    end
    else
    begin
      second_stroke <= ~issue;
      refresh_time  <= refresh_strobe ^ refresh_ack;
      if (settle && (cmd_issued == `CMD_ARSR))
        refresh_ack <= refresh_strobe; // Refresh served
      if (issue)
        state_rw <= hit_rand || hit_bulk;
    end
  end

  // Every command is followed by a NOOP cycle
  a_no_back_to_back: assert property (@(posedge INPUT_CLK) disable iff (RST)
    issue |=> !issue);

endmodule

// ==== hw/ddr_consts.svh ====
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

// ------------------------------------------------------------
// DDR2 command codes, {RAS,CAS,WE}
// ------------------------------------------------------------
`define CMD_NOOP 3'b111 // No operation
`define CMD_ACTV 3'b011 // Row open
`define CMD_READ 3'b101
`define CMD_WRTE 3'b100
`define CMD_PRCH 3'b010 // Row close
`define CMD_ARSR 3'b001 // Auto refresh

// ------------------------------------------------------------
// Field widths
// ------------------------------------------------------------
`define CMD_W      3
`define ROW_W      14
`define BANK_W     3
`define COL_W      9
`define PAGE_W     17 // Row and bank together
`define ADDR_W     26
`define DDR_ADDR_W 14

// ------------------------------------------------------------
// Hold counter reload values, by last command
// ------------------------------------------------------------
`define HOLD_W    4
`define HOLD_ARSR 4'h3
`define HOLD_ACTV 4'hc
`define HOLD_IDLE 4'he
`define HOLD_RW   4'hb

// A10 high selects all banks
`define PRCH_ALL_ADDR 14'h0400

`endif

// ==== hw/ddr_hold_timer.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_hold_timer
(
  input  logic              INPUT_CLK,
  input  logic              RST,
  input  logic              settle,
  input  logic [`CMD_W-1:0] cmd_issued,
  input  logic              hit_any,
  input  logic              page_active,
  input  logic              last_write,
  output logic              slot_open,
  output logic              actv_done
);

  logic [`HOLD_W-1:0] counter;
  logic [2:0]         actv_timeout; // ACTIVATE to PRECHARGE spacing
  logic               extra_pass;   // One full wrap after refresh
  logic               norm_reached;
  logic               dlay_reached;
  logic               slot_next;

  assign norm_reached = counter >= 4'hd;
  assign dlay_reached = counter >= 4'he; // Write recovery before PRECHARGE

  always_comb
  begin
    if (settle)
      slot_next = 1'b0;
    else if (hit_any)
      slot_next = norm_reached;
    else if (extra_pass)
      slot_next = 1'b0;
    else if (page_active && last_write)
      slot_next = dlay_reached;
    else
      slot_next = norm_reached;
  end

  assign actv_done = actv_timeout[2];

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      counter      <= {`HOLD_W{1'b1}};
      slot_open    <= 1'b0;
      extra_pass   <= 1'b1;
      actv_timeout <= 3'h7;
    end
    else
    begin
      slot_open <= slot_next;

      if (settle && (cmd_issued == `CMD_ACTV))
        actv_timeout <= 3'h0;
      else if (!actv_timeout[2])
        actv_timeout <= actv_timeout + 3'h1;

      if (settle)
      begin
        case (cmd_issued)
          `CMD_ARSR: counter <= `HOLD_ARSR;
          `CMD_ACTV: counter <= `HOLD_ACTV;
          `CMD_NOOP: counter <= `HOLD_IDLE;
          default:   counter <= `HOLD_RW;
        endcase
        if (cmd_issued == `CMD_ARSR)
          extra_pass <= 1'b1;
      end
      else
      begin
        counter <= counter + {{(`HOLD_W-1){1'b0}}, ~slot_open};
        if (counter == '0)
          extra_pass <= 1'b0; // Wrapped once
      end
    end
  end

endmodule

// ==== hw/ddr_page_tracker.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_page_tracker
(
  input  logic                     INPUT_CLK,
  input  logic                     RST,
  input  logic                     issue,
  input  logic                     settle,
  input  logic [`CMD_W-1:0]        cmd_issued,
  input  logic                     refresh_time,
  input  ddr_sched_pkg::req_addr_u rand_addr,
  input  logic                     rand_req,
  input  logic                     rand_we,
  input  ddr_sched_pkg::req_addr_u bulk_addr,
  input  logic                     bulk_req,
  input  logic                     bulk_we,
  output logic                     hit_rand,
  output logic                     hit_bulk,
  output logic                     page_active,
  output logic                     last_write,
  output logic [`PAGE_W-1:0]       cur_page,
  output logic [`BANK_W-1:0]       cur_bank,
  output logic                     rand_req_q,
  output logic                     bulk_req_q,
  output logic                     write_sel
);
  import ddr_sched_pkg::*;

  logic      rand_we_q;
  logic      bulk_we_q;
  logic      page_ok;
  req_addr_u next_addr;

  // No new hits while a refresh waits
  assign page_ok = page_active && !refresh_time;

  // Bulk wins the next row
  assign next_addr = bulk_req ? bulk_addr : rand_addr;

  always_comb
  begin
    if (hit_bulk)
      write_sel = bulk_we_q;
    else if (hit_rand)
      write_sel = rand_we_q;
    else if (bulk_req_q)
      write_sel = bulk_we_q;
    else
      write_sel = rand_req_q && rand_we_q;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_req_q  <= 1'b0;
      bulk_req_q  <= 1'b0;
      hit_rand    <= 1'b0;
      hit_bulk    <= 1'b0;
      page_active <= 1'b0;
      last_write  <= 1'b0;
    end
    else
    begin
      rand_req_q <= rand_req;
      bulk_req_q <= bulk_req;
      hit_rand   <= rand_req && page_ok && (rand_addr.pg.page == cur_page);
      hit_bulk   <= bulk_req && page_ok && (bulk_addr.pg.page == cur_page);

      if (settle)
      begin
        if (cmd_issued == `CMD_ACTV)
          page_active <= 1'b1;
        if (cmd_issued == `CMD_PRCH)
          page_active <= 1'b0;
        if (cmd_issued == `CMD_WRTE)
          last_write <= 1'b1;
        else if (cmd_issued != `CMD_NOOP)
          last_write <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Page of the next ACTIVATE, frozen once a row is open
  // ------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    rand_we_q <= rand_we;
    bulk_we_q <= bulk_we;
    if (!page_active && !issue && !settle)
    begin
      cur_page <= next_addr.pg.page;
      cur_bank <= next_addr.rbc.bank;
    end
  end

  a_rw_needs_row: assert property (@(posedge INPUT_CLK) disable iff (RST)
    (settle && ((cmd_issued == `CMD_READ) || (cmd_issued == `CMD_WRTE))) |-> page_active);

endmodule

// ==== hw/ddr_sched_pkg.sv ====
`include "ddr_consts.svh"

package ddr_sched_pkg;

  // Row, bank and column fields
  typedef struct packed
  {
    logic [`ROW_W-1:0]  row;
    logic [`BANK_W-1:0] bank;
    logic [`COL_W-1:0]  col;
  } req_rbc_s;

  // Page is row and bank as one compare key
  typedef struct packed
  {
    logic [`PAGE_W-1:0] page;
    logic [`COL_W-1:0]  col;
  } req_page_s;

  typedef union packed
  {
    req_rbc_s  rbc;
    req_page_s pg;
  } req_addr_u;

endpackage

// ==== hw/ddr_sched_top.sv ====
`timescale 1ns/1ns
`include "ddr_consts.svh"

module ddr_sched_top
(
  input  logic                     INPUT_CLK,
  input  logic                     RST,
  input  logic                     refresh_strobe,
  input  ddr_sched_pkg::req_addr_u rand_addr,
  input  logic                     rand_we,
  input  logic                     rand_req,
  output logic                     rand_grant,
  input  ddr_sched_pkg::req_addr_u bulk_addr,
  input  logic                     bulk_we,
  input  logic                     bulk_req,
  output logic                     bulk_grant,
  output logic [`CMD_W-1:0]        ddr_cmd,
  output logic [`DDR_ADDR_W-1:0]   ddr_addr,
  output logic [`BANK_W-1:0]       ddr_bank
);

  logic               issue;
  logic               settle;
  logic               refresh_time;
  logic               hit_rand;
  logic               hit_bulk;
  logic               page_active;
  logic               last_write;
  logic [`PAGE_W-1:0] cur_page;
  logic [`BANK_W-1:0] cur_bank;
  logic               rand_req_q;
  logic               bulk_req_q;
  logic               write_sel;
  logic [`CMD_W-1:0]  cmd_issued;
  logic               slot_open;
  logic               actv_done;

  ddr_cmd_sequencer u_seq
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_req       (rand_req),
    .hit_rand       (hit_rand),
    .hit_bulk       (hit_bulk),
    .bulk_req_q     (bulk_req_q),
    .rand_req_q     (rand_req_q),
    .write_sel      (write_sel),
    .last_write     (last_write),
    .slot_open      (slot_open),
    .cmd_issued     (cmd_issued),
    .issue          (issue),
    .settle         (settle),
    .refresh_time   (refresh_time)
  );

  ddr_hold_timer u_timer
  (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .settle      (settle),
    .cmd_issued  (cmd_issued),
    .hit_any     (hit_rand | hit_bulk),
    .page_active (page_active),
    .last_write  (last_write),
    .slot_open   (slot_open),
    .actv_done   (actv_done)
  );

  ddr_page_tracker u_track
  (
    .INPUT_CLK    (INPUT_CLK),
    .RST          (RST),
    .issue        (issue),
    .settle       (settle),
    .cmd_issued   (cmd_issued),
    .refresh_time (refresh_time),
    .rand_addr    (rand_addr),
    .rand_req     (rand_req),
    .rand_we      (rand_we),
    .bulk_addr    (bulk_addr),
    .bulk_req     (bulk_req),
    .bulk_we      (bulk_we),
    .hit_rand     (hit_rand),
    .hit_bulk     (hit_bulk),
    .page_active  (page_active),
    .last_write   (last_write),
    .cur_page     (cur_page),
    .cur_bank     (cur_bank),
    .rand_req_q   (rand_req_q),
    .bulk_req_q   (bulk_req_q),
    .write_sel    (write_sel)
  );

  ddr_cmd_encoder u_enc
  (
    .INPUT_CLK    (INPUT_CLK),
    .RST          (RST),
    .issue        (issue),
    .hit_rand     (hit_rand),
    .hit_bulk     (hit_bulk),
    .page_active  (page_active),
    .refresh_time (refresh_time),
    .actv_done    (actv_done),
    .write_sel    (write_sel),
    .rand_addr    (rand_addr),
    .bulk_addr    (bulk_addr),
    .cur_bank     (cur_bank),
    .cur_page     (cur_page),
    .cmd_issued   (cmd_issued),
    .ddr_cmd      (ddr_cmd),
    .ddr_addr     (ddr_addr),
    .ddr_bank     (ddr_bank),
    .rand_grant   (rand_grant),
    .bulk_grant   (bulk_grant)
  );

endmodule
